// ==== build.f ====
verilog/ts_pkg.sv
verilog/thread_if.sv
verilog/thread_slot.sv
verilog/hazard_tracker.sv
verilog/issue_arbiter.sv
verilog/thread_select_stage.sv
verif/tb_thread_select.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the thread select stage testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f build.f \
	--top-module tb_thread_select \
	-o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
	exit 1
fi
exit 0

// ==== verif/tb_thread_select.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the thread select stage
// Drives enqueue, writeback, rollback and suspend traffic, models FIFO
// occupancy and checks issue order, latency and hazard blocking
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_thread_select
	import ts_pkg::*;
	();

	localparam int NT = 4;
	localparam int DEPTH = 5;
	localparam int TEST_CYCLES = 7 * 80;

	logic clk;
	logic reset;
	decoded_instruction_t id_instruction;
	logic id_instruction_valid;
	logic [1:0] id_thread_idx;
	logic wb_writeback_en;
	logic [1:0] wb_writeback_thread_idx;
	logic wb_writeback_is_vector;
	reg_idx_t wb_writeback_reg;
	logic wb_rollback_en;
	logic [1:0] wb_rollback_thread_idx;
	pipeline_sel_t wb_rollback_pipeline;
	logic [NT-1:0] cr_thread_enable;
	logic [NT-1:0] wb_suspend_thread_oh;
	logic [NT-1:0] wake_bitmap;
	logic [NT-1:0] ts_fetch_en;
	logic ts_instruction_valid;
	decoded_instruction_t ts_instruction;
	logic [1:0] ts_thread_idx;

	int cyc = 0;
	int occ[NT];
	logic [NT-1:0] exp_fetch;
	logic [31:0] seed = 32'h2afc0f39;
	int out_tag[$];
	int out_thr[$];
	int out_cyc[$];
	string cur_test;
	int test_errs = 0;
	int pass_count = 0;
	int fail_count = 0;

	thread_select_stage #(.NUM_THREADS(NT), .FIFO_DEPTH(DEPTH)) uut (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	// Occupancy model, enqueue and rollback are taken at the clock edge
	always @(posedge clk)
	begin
		if (reset)
		begin
			for (int t = 0; t < NT; t++)
				occ[t] = 0;
		end
		else
		begin
			if (id_instruction_valid)
				occ[id_thread_idx] = occ[id_thread_idx] + 1;
			if (wb_rollback_en)
				occ[wb_rollback_thread_idx] = 0;
		end
	end

	// An issued instruction is logged on the edge that ends its output cycle
	// The edge number recorded is the one that loaded the output register
	always @(posedge clk)
	begin
		if (!reset && ts_instruction_valid)
		begin
			out_tag.push_back(ts_instruction.tag);
			out_thr.push_back(ts_thread_idx);
			out_cyc.push_back(cyc);
		end
	end

	// The model's occupancy drops within the output cycle, before the next edge
	always @(negedge clk)
	begin
		if (!reset && ts_instruction_valid)
			occ[ts_thread_idx] = occ[ts_thread_idx] - 1;
	end

	always_comb
	begin
		for (int t = 0; t < NT; t++)
			exp_fetch[t] = cr_thread_enable[t] && occ[t] <= DEPTH - ALMOST_FULL_MARGIN;
	end

	task automatic fail_check(input string what, input int exp, input int act);
		$display("ERR %s %s expected %0h actual %0h", cur_test, what, exp, act);
		test_errs++;
	endtask

	assert property (@(posedge clk) disable iff (reset) ts_fetch_en == exp_fetch)
		else fail_check("fetch_en", $sampled(exp_fetch), $sampled(ts_fetch_en));

	// A single cycle result must not share writeback with a multi cycle result
	assert property (@(posedge clk) disable iff (reset)
		(ts_instruction_valid && ts_instruction.pipeline_sel == PIPE_SCYCLE_ARITH)
		|-> !$past(ts_instruction_valid
			&& ts_instruction.pipeline_sel == PIPE_MCYCLE_ARITH, 4))
		else
		begin
			$display("%s: single cycle instruction issued four cycles after a multi cycle one",
				cur_test);
			test_errs++;
		end

	task automatic check_eq(input string what, input int exp, input int act);
		assert (exp == act)
			else fail_check(what, exp, act);
	endtask

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Register 0 is avoided so every picked register is clearly nonzero
	function automatic reg_idx_t random_reg();
		return reg_idx_t'(1 + (lcg_next() >> 8) % 31);
	endfunction

	function automatic decoded_instruction_t make_instr(input int tag, input pipeline_sel_t pipe,
		input logic dst_en, input reg_idx_t dst, input logic src_en, input reg_idx_t src);
		decoded_instruction_t ins;
		ins = '0;
		ins.tag = 8'(tag);
		ins.pipeline_sel = pipe;
		ins.has_dest = dst_en;
		ins.dest_reg = dst;
		ins.has_scalar1 = src_en;
		ins.scalar_sel1 = src;
		return ins;
	endfunction

	// Waits for the falling edge and drops every one-cycle strobe
	task automatic tick();
		@(negedge clk);
		id_instruction_valid = 1'b0;
		wb_writeback_en = 1'b0;
		wb_rollback_en = 1'b0;
		wb_suspend_thread_oh = '0;
		wake_bitmap = '0;
	endtask

	// Returns the edge number at which the DUT takes the instruction
	task automatic enqueue(input int thr, input decoded_instruction_t ins, output int edge_n);
		tick();
		id_instruction = ins;
		id_instruction_valid = 1'b1;
		id_thread_idx = 2'(thr);
		edge_n = cyc + 1;
	endtask

	task automatic wait_outputs(input int n, input int limit);
		int i;
		for (i = 0; i < limit && out_tag.size() < n; i++)
			tick();
		if (out_tag.size() < n)
		begin
			$display("%s: only %0d of %0d instructions came out in time",
				cur_test, out_tag.size(), n);
			test_errs++;
		end
	endtask

	task automatic idle(input int n);
		for (int i = 0; i < n; i++)
			tick();
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		out_tag.delete();
		out_thr.delete();
		out_cyc.delete();
	endtask

	task automatic end_test();
		if (test_errs == 0)
		begin
			$display("PASS %s", cur_test);
			pass_count++;
		end
		else
		begin
			$display("FAIL %s (%0d errors)", cur_test, test_errs);
			fail_count++;
		end
		test_errs = 0;
	endtask

	initial
	begin
		#(TEST_CYCLES * 20 + 400);
		$display("Watchdog expired before the tests completed");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		int e0;
		int e;
		int wb_edge;
		int mc_cyc;
		reg_idx_t r;

		reset = 1'b1;
		id_instruction = '0;
		id_instruction_valid = 1'b0;
		id_thread_idx = '0;
		wb_writeback_en = 1'b0;
		wb_writeback_thread_idx = '0;
		wb_writeback_is_vector = 1'b0;
		wb_writeback_reg = '0;
		wb_rollback_en = 1'b0;
		wb_rollback_thread_idx = '0;
		wb_rollback_pipeline = PIPE_SCYCLE_ARITH;
		cr_thread_enable = '1;
		wb_suspend_thread_oh = '0;
		wake_bitmap = '0;
		repeat (2) @(posedge clk);
		tick();
		reset = 1'b0;
		idle(2);

		// In-order issue and the two cycle latency of an unblocked thread
		begin_test("in_order");
		enqueue(0, make_instr(8'h11, PIPE_SCYCLE_ARITH, 0, 0, 0, 0), e0);
		enqueue(0, make_instr(8'h12, PIPE_SCYCLE_ARITH, 0, 0, 0, 0), e);
		enqueue(0, make_instr(8'h13, PIPE_SCYCLE_ARITH, 0, 0, 0, 0), e);
		wait_outputs(3, 20);
		for (int i = 0; i < out_tag.size(); i++)
			check_eq("tag", 8'h11 + i, out_tag[i]);
		if (out_cyc.size() > 0)
			check_eq("first output edge", e0 + 1, out_cyc[0]);
		end_test();

		// Read after write is held until the writeback edge
		begin_test("raw_hazard");
		r = random_reg();
		enqueue(1, make_instr(8'h21, PIPE_SCYCLE_ARITH, 1, r, 0, 0), e);
		enqueue(1, make_instr(8'h22, PIPE_SCYCLE_ARITH, 0, 0, 1, r), e);
		idle(6);
		check_eq("outputs before writeback", 1, out_tag.size());
		tick();
		wb_writeback_en = 1'b1;
		wb_writeback_thread_idx = 2'd1;
		wb_writeback_is_vector = 1'b0;
		wb_writeback_reg = r;
		wb_edge = cyc + 1;
		wait_outputs(2, 20);
		if (out_tag.size() == 2)
		begin
			check_eq("reader tag", 8'h22, out_tag[1]);
			check_eq("reader output edge", wb_edge + 1, out_cyc[1]);
		end
		end_test();

		// Round robin over enabled threads, thread 3 held off
		begin_test("round_robin");
		cr_thread_enable = '0;
		for (int k = 0; k < 2; k++)
			for (int t = 0; t < NT; t++)
				enqueue(t, make_instr(8'h30 + 4 * k + t, PIPE_SCYCLE_ARITH, 0, 0, 0, 0), e);
		tick();
		cr_thread_enable = 4'b0111;
		wait_outputs(6, 20);
		idle(4);
		check_eq("issue count", 6, out_tag.size());
		for (int i = 0; i < out_thr.size(); i++)
		begin
			check_eq("disabled thread", 1, out_thr[i] != 3);
			if (i > 0)
				check_eq("rotation", (out_thr[i - 1] + 1) % 3, out_thr[i]);
		end
		tick();
		wb_rollback_en = 1'b1;
		wb_rollback_thread_idx = 2'd3;
		tick();
		cr_thread_enable = '1;
		end_test();

		// Suspended thread waits for wake while its neighbour runs
		begin_test("suspend_wake");
		cr_thread_enable = '0;
		for (int i = 0; i < 3; i++)
		begin
			enqueue(0, make_instr(8'h40 + i, PIPE_SCYCLE_ARITH, 0, 0, 0, 0), e);
			enqueue(1, make_instr(8'h48 + i, PIPE_SCYCLE_ARITH, 0, 0, 0, 0), e);
		end
		tick();
		wb_suspend_thread_oh = 4'b0001;
		tick();
		cr_thread_enable = '1;
		idle(8);
		check_eq("outputs while suspended", 3, out_tag.size());
		for (int i = 0; i < out_thr.size(); i++)
			check_eq("running thread", 1, out_thr[i]);
		tick();
		wake_bitmap = 4'b0001;
		wait_outputs(6, 20);
		tick();
		wb_suspend_thread_oh = 4'b0001;
		wake_bitmap = 4'b0001;
		enqueue(0, make_instr(8'h4f, PIPE_SCYCLE_ARITH, 0, 0, 0, 0), e);
		wait_outputs(7, 20);
		if (out_tag.size() == 7)
			check_eq("tag after suspend with wake", 8'h4f, out_tag[6]);
		end_test();

		// Rollback drops queued work and frees in-flight destinations
		begin_test("rollback");
		r = random_reg();
		enqueue(2, make_instr(8'h50, PIPE_SCYCLE_ARITH, 1, r, 0, 0), e);
		enqueue(2, make_instr(8'h51, PIPE_SCYCLE_ARITH, 0, 0, 1, r), e);
		enqueue(2, make_instr(8'h52, PIPE_SCYCLE_ARITH, 0, 0, 0, 0), e);
		wait_outputs(1, 20);
		tick();
		wb_rollback_en = 1'b1;
		wb_rollback_thread_idx = 2'd2;
		wb_rollback_pipeline = PIPE_SCYCLE_ARITH;
		enqueue(2, make_instr(8'h53, PIPE_SCYCLE_ARITH, 0, 0, 1, r), e);
		wait_outputs(2, 20);
		idle(4);
		check_eq("issue count", 2, out_tag.size());
		if (out_tag.size() == 2)
			check_eq("reader tag", 8'h53, out_tag[1]);
		end_test();

		// Fetch enable drops as a blocked thread's FIFO fills up
		begin_test("fetch_enable");
		tick();
		wb_suspend_thread_oh = 4'b0001;
		for (int i = 0; i < DEPTH; i++)
			enqueue(0, make_instr(8'h60 + i, PIPE_SCYCLE_ARITH, 0, 0, 0, 0), e);
		tick();
		check_eq("fetch_en when full", 0, ts_fetch_en[0]);
		wake_bitmap = 4'b0001;
		wait_outputs(DEPTH, 20);
		end_test();

		// Writeback port reservation after a multi cycle issue
		begin_test("writeback_reservation");
		cr_thread_enable = '0;
		enqueue(1, make_instr(8'h70, PIPE_MCYCLE_ARITH, 0, 0, 0, 0), e);
		for (int i = 0; i < 5; i++)
			enqueue(2, make_instr(8'h71 + i, PIPE_SCYCLE_ARITH, 0, 0, 0, 0), e);
		tick();
		cr_thread_enable = '1;
		wait_outputs(6, 30);
		mc_cyc = -100;
		for (int i = 0; i < out_tag.size(); i++)
			if (out_tag[i] == 8'h70)
				mc_cyc = out_cyc[i];
		for (int i = 0; i < out_tag.size(); i++)
			check_eq("issue four cycles after mcycle", 0, out_cyc[i] == mc_cyc + 4);
		end_test();

		$display("Tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== verilog/hazard_tracker.sv ====
////////////////////////////////////////////////////////////////////////////
// Hazard tracker
// Reserves writeback slots between pipelines of different lengths and
// remembers recent destinations so a rollback can free their registers
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module hazard_tracker
	import ts_pkg::*;
	#(
		parameter int NUM_THREADS = 4,
		localparam int TIDX_W = $clog2(NUM_THREADS)
	)
	(
		input logic clk,
		input logic reset,
		input logic wb_rollback_en,
		input logic [TIDX_W-1:0] wb_rollback_thread_idx,
		input pipeline_sel_t wb_rollback_pipeline,
		thread_if.tracker tif[NUM_THREADS]
	);

	logic [NUM_THREADS-1:0] grant_vec;
	logic [NUM_THREADS-1:0] flush_vec;
	decoded_instruction_t head_arr[NUM_THREADS];
	scoreboard_t dest_arr[NUM_THREADS];
	scoreboard_t clear_arr[NUM_THREADS];
	logic issue_any;
	logic [TIDX_W-1:0] issue_thread;
	pipeline_sel_t issue_pipe;
	logic issue_has_dest;
	scoreboard_t issue_bitmap;
	logic rb_valid[ROLLBACK_STAGES];
	logic [TIDX_W-1:0] rb_thread[ROLLBACK_STAGES];
	scoreboard_t rb_bitmap[ROLLBACK_STAGES];
	logic [WRITEBACK_ALLOC_STAGES-1:0] wb_alloc;
	logic [WRITEBACK_ALLOC_STAGES-1:0] wb_alloc_nxt;

	genvar g;
	generate
		for (g = 0; g < NUM_THREADS; g++)
		begin : g_thread
			assign grant_vec[g] = tif[g].grant;
			assign head_arr[g] = tif[g].head_instr;
			assign dest_arr[g] = tif[g].dest_bitmap;
			assign flush_vec[g] = wb_rollback_en && wb_rollback_thread_idx == TIDX_W'(g);
			assign tif[g].flush = flush_vec[g];
			assign tif[g].clear_bitmap = clear_arr[g];

			// Stage 0 is the slot one cycle out, stage 1 the slot two cycles out
			assign tif[g].conflict_scycle = wb_alloc[0];
			assign tif[g].conflict_mem = wb_alloc[1];
		end
	endgenerate

	// The grant is one-hot, so OR-ing the granted entries selects the issued one
	always_comb
	begin
		issue_any = |grant_vec;
		issue_thread = '0;
		issue_pipe = PIPE_SCYCLE_ARITH;
		issue_has_dest = 1'b0;
		issue_bitmap = '0;
		for (int i = 0; i < NUM_THREADS; i++)
		begin
			if (grant_vec[i])
			begin
				issue_thread = TIDX_W'(i);
				issue_pipe = head_arr[i].pipeline_sel;
				issue_has_dest = head_arr[i].has_dest;
				issue_bitmap = dest_arr[i];
			end
		end
	end

	// Any issue takes its writeback slot even without a destination register
	// A multi-cycle result arrives four cycles out, a memory result one cycle out
	always_comb
	begin
		wb_alloc_nxt = wb_alloc >> 1;
		if (issue_any && issue_pipe == PIPE_MCYCLE_ARITH)
			wb_alloc_nxt[WRITEBACK_ALLOC_STAGES - 1] = 1'b1;
		else if (issue_any && issue_pipe == PIPE_MEM)
			wb_alloc_nxt[0] = 1'b1;
	end

	// Release the destinations of the rolled back thread's instructions still in flight
	always_comb
	begin
		for (int t = 0; t < NUM_THREADS; t++)
		begin
			clear_arr[t] = '0;
			if (flush_vec[t])
			begin
				for (int i = 0; i < ROLLBACK_STAGES - 1; i++)
				begin
					if (rb_valid[i] && rb_thread[i] == TIDX_W'(t))
						clear_arr[t] |= rb_bitmap[i];
				end

				// The memory pipeline is one stage longer, so the oldest record is only
				// still in flight when the rollback came from there
				if (rb_valid[ROLLBACK_STAGES - 1]
					&& rb_thread[ROLLBACK_STAGES - 1] == TIDX_W'(t)
					&& wb_rollback_pipeline == PIPE_MEM)
					clear_arr[t] |= rb_bitmap[ROLLBACK_STAGES - 1];
			end
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < ROLLBACK_STAGES; i++)
				rb_valid[i] <= 1'b0;
			wb_alloc <= '0;
		end
		else
		begin
			rb_valid[0] <= issue_any && issue_has_dest;

			// A record of the rolled back thread is dropped as it moves down
			for (int i = 1; i < ROLLBACK_STAGES; i++)
				rb_valid[i] <= rb_valid[i - 1]
					&& !(wb_rollback_en && rb_thread[i - 1] == wb_rollback_thread_idx);
			wb_alloc <= wb_alloc_nxt;
		end
	end

	always_ff @(posedge clk)
	begin
		rb_thread[0] <= issue_thread;
		rb_bitmap[0] <= issue_bitmap;
		for (int i = 1; i < ROLLBACK_STAGES; i++)
		begin
			rb_thread[i] <= rb_thread[i - 1];
			rb_bitmap[i] <= rb_bitmap[i - 1];
		end
	end

	// Only one thread issues per cycle, and never the one being rolled back
	assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant_vec) && (grant_vec & flush_vec) == '0);

endmodule

// ==== verilog/issue_arbiter.sv ====
////////////////////////////////////////////////////////////////////////////
// Issue arbiter
// Round robin choice among the ready threads and the register that hands
// the chosen instruction on to operand fetch
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module issue_arbiter
	import ts_pkg::*;
	#(
		parameter int NUM_THREADS = 4,
		localparam int TIDX_W = $clog2(NUM_THREADS)
	)
	(
		input logic clk,
		input logic reset,
		thread_if.arbiter tif[NUM_THREADS],
		output logic ts_instruction_valid,
		output decoded_instruction_t ts_instruction,
		output logic [TIDX_W-1:0] ts_thread_idx
	);

	logic [NUM_THREADS-1:0] ready_vec;
	logic [NUM_THREADS-1:0] grant_vec;
	decoded_instruction_t head_arr[NUM_THREADS];
	logic [TIDX_W-1:0] last_grant;
	logic [TIDX_W-1:0] grant_idx;
	logic grant_any;

	genvar g;
	generate
		for (g = 0; g < NUM_THREADS; g++)
		begin : g_thread
			assign ready_vec[g] = tif[g].ready;
			assign head_arr[g] = tif[g].head_instr;
			assign tif[g].grant = grant_vec[g];
		end
	endgenerate

	// Search starts just past the last winner and wraps around once
	// The last winner itself is looked at last, so it cannot starve the others
	always_comb
	begin
		int cand;
		grant_vec = '0;
		grant_idx = '0;
		grant_any = 1'b0;
		for (int off = 1; off <= NUM_THREADS; off++)
		begin
			cand = (int'(last_grant) + off) % NUM_THREADS;
			if (!grant_any && ready_vec[cand])
			begin
				grant_any = 1'b1;
				grant_idx = TIDX_W'(cand);
			end
		end
		if (grant_any)
			grant_vec[grant_idx] = 1'b1;
	end

	// After reset the pointer sits on the last thread so thread 0 goes first
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			last_grant <= TIDX_W'(NUM_THREADS - 1);
			ts_instruction_valid <= 1'b0;
		end
		else
		begin
			ts_instruction_valid <= grant_any;
			if (grant_any)
				last_grant <= grant_idx;
		end
	end

	// Payload only loads on an issue and is qualified by the valid bit downstream
	always_ff @(posedge clk)
	begin
		if (grant_any)
		begin
			ts_instruction <= head_arr[grant_idx];
			ts_thread_idx <= grant_idx;
		end
	end

	// Some ready thread always wins, and the winner is one of the ready ones
	assert property (@(posedge clk) disable iff (reset)
		((|ready_vec) -> $onehot(grant_vec)) && (grant_vec & ~ready_vec) == '0);

endmodule

// ==== verilog/thread_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Per-thread link of the thread select stage
// Joins one thread slot with the hazard tracker and the issue arbiter
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

interface thread_if
	import ts_pkg::*;
	();

	// Slot side, head of the FIFO and whether it may go this cycle
	logic ready;
	decoded_instruction_t head_instr;
	scoreboard_t dest_bitmap;

	// One-hot grant bit for this thread
	logic grant;

	// Hazard side, rollback repair and writeback port collisions
	scoreboard_t clear_bitmap;
	logic flush;
	logic conflict_scycle;
	logic conflict_mem;

	modport slot(output ready, head_instr, dest_bitmap,
		input grant, clear_bitmap, flush, conflict_scycle, conflict_mem);

	modport tracker(input grant, head_instr, dest_bitmap,
		output clear_bitmap, flush, conflict_scycle, conflict_mem);

	modport arbiter(input ready, head_instr, output grant);

endinterface

// ==== verilog/thread_select_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Thread select stage
// Each cycle picks one ready hardware thread by round robin and registers
// its decoded instruction toward operand fetch
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module thread_select_stage
	import ts_pkg::*;
	#(
		parameter int NUM_THREADS = 4,
		parameter int FIFO_DEPTH = 5,
		localparam int TIDX_W = $clog2(NUM_THREADS)
	)
	(
		input logic clk,
		input logic reset,
		input decoded_instruction_t id_instruction,
		input logic id_instruction_valid,
		input logic [TIDX_W-1:0] id_thread_idx,
		input logic wb_writeback_en,
		input logic [TIDX_W-1:0] wb_writeback_thread_idx,
		input logic wb_writeback_is_vector,
		input reg_idx_t wb_writeback_reg,
		input logic wb_rollback_en,
		input logic [TIDX_W-1:0] wb_rollback_thread_idx,
		input pipeline_sel_t wb_rollback_pipeline,
		input logic [NUM_THREADS-1:0] cr_thread_enable,
		input logic [NUM_THREADS-1:0] wb_suspend_thread_oh,
		input logic [NUM_THREADS-1:0] wake_bitmap,
		output logic [NUM_THREADS-1:0] ts_fetch_en,
		output logic ts_instruction_valid,
		output decoded_instruction_t ts_instruction,
		output logic [TIDX_W-1:0] ts_thread_idx
	);

	thread_if tif[NUM_THREADS] ();

	// Shared buses go to every slot, each slot matches the thread index against its own
	genvar g;
	generate
		for (g = 0; g < NUM_THREADS; g++)
		begin : g_slot
			thread_slot #(
				.NUM_THREADS(NUM_THREADS),
				.FIFO_DEPTH(FIFO_DEPTH),
				.THREAD_ID(g)
			) u_slot (
				.clk(clk),
				.reset(reset),
				.id_instruction(id_instruction),
				.id_instruction_valid(id_instruction_valid),
				.id_thread_idx(id_thread_idx),
				.wb_writeback_en(wb_writeback_en),
				.wb_writeback_thread_idx(wb_writeback_thread_idx),
				.wb_writeback_is_vector(wb_writeback_is_vector),
				.wb_writeback_reg(wb_writeback_reg),
				.thread_enable(cr_thread_enable[g]),
				.suspend(wb_suspend_thread_oh[g]),
				.wake(wake_bitmap[g]),
				.fetch_en(ts_fetch_en[g]),
				.tif(tif[g])
			);
		end
	endgenerate

	hazard_tracker #(.NUM_THREADS(NUM_THREADS)) u_tracker (
		.clk(clk),
		.reset(reset),
		.wb_rollback_en(wb_rollback_en),
		.wb_rollback_thread_idx(wb_rollback_thread_idx),
		.wb_rollback_pipeline(wb_rollback_pipeline),
		.tif(tif)
	);

	issue_arbiter #(.NUM_THREADS(NUM_THREADS)) u_arbiter (
		.clk(clk),
		.reset(reset),
		.tif(tif),
		.ts_instruction_valid(ts_instruction_valid),
		.ts_instruction(ts_instruction),
		.ts_thread_idx(ts_thread_idx)
	);

endmodule

// ==== verilog/thread_slot.sv ====
////////////////////////////////////////////////////////////////////////////
// Thread slot
// One hardware thread's instruction FIFO, register scoreboard and cache
// miss suspend flag, plus the test of whether its FIFO head may issue
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module thread_slot
	import ts_pkg::*;
	#(
		parameter int NUM_THREADS = 4,
		parameter int FIFO_DEPTH = 5,
		parameter int THREAD_ID = 0,
		localparam int TIDX_W = $clog2(NUM_THREADS)
	)
	(
		input logic clk,
		input logic reset,
		input decoded_instruction_t id_instruction,
		input logic id_instruction_valid,
		input logic [TIDX_W-1:0] id_thread_idx,
		input logic wb_writeback_en,
		input logic [TIDX_W-1:0] wb_writeback_thread_idx,
		input logic wb_writeback_is_vector,
		input reg_idx_t wb_writeback_reg,
		input logic thread_enable,
		input logic suspend,
		input logic wake,
		output logic fetch_en,
		thread_if.slot tif
	);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	decoded_instruction_t fifo_mem[FIFO_DEPTH];
	decoded_instruction_t head;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic enqueue;
	logic dequeue;
	logic fifo_empty;
	logic fifo_full;
	scoreboard_t scoreboard;
	scoreboard_t dest_bitmap;
	scoreboard_t dep_bitmap;
	scoreboard_t wb_clear_bitmap;
	logic blocked;
	logic wb_conflict;

	// Advance a FIFO pointer, wrapping at the depth which need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		else
			return ptr + 1'b1;
	endfunction

	// Enqueue and writeback are broadcast to all slots, each picks out its own
	assign enqueue = id_instruction_valid && id_thread_idx == TIDX_W'(THREAD_ID);
	assign dequeue = tif.grant;
	assign fifo_empty = count == '0;
	assign fifo_full = count == CNT_W'(FIFO_DEPTH);

	// Fetch runs a few stages ahead, so it is stopped while there is still room
	assign fetch_en = thread_enable && count <= CNT_W'(FIFO_DEPTH - ALMOST_FULL_MARGIN);

	// A rollback throws away everything queued, including an enqueue in the same cycle
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else if (tif.flush)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (enqueue)
				wr_ptr <= ptr_next(wr_ptr);
			if (dequeue)
				rd_ptr <= ptr_next(rd_ptr);
			if (enqueue && !dequeue)
				count <= count + 1'b1;
			else if (dequeue && !enqueue)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (enqueue)
			fifo_mem[wr_ptr] <= id_instruction;
	end

	assign head = fifo_mem[rd_ptr];
	assign tif.head_instr = head;

	// Bits the head instruction marks busy when it issues
	always_comb
	begin
		dest_bitmap = '0;
		if (head.has_dest)
			dest_bitmap = reg_bitmap(head.dest_is_vector, head.dest_reg);
	end

	assign tif.dest_bitmap = dest_bitmap;

	// Sources catch read after write hazards
	// Including the destination also holds back a second writer of the same register
	always_comb
	begin
		dep_bitmap = dest_bitmap;
		if (head.has_scalar1)
			dep_bitmap |= reg_bitmap(1'b0, head.scalar_sel1);
		if (head.has_scalar2)
			dep_bitmap |= reg_bitmap(1'b0, head.scalar_sel2);
		if (head.has_vector1)
			dep_bitmap |= reg_bitmap(1'b1, head.vector_sel1);
		if (head.has_vector2)
			dep_bitmap |= reg_bitmap(1'b1, head.vector_sel2);
	end

	// The collision flag checked depends on where this instruction writes back
	always_comb
	begin
		case (head.pipeline_sel)
			PIPE_SCYCLE_ARITH: wb_conflict = tif.conflict_scycle;
			PIPE_MEM: wb_conflict = tif.conflict_mem;
			default: wb_conflict = 1'b0;
		endcase
	end

	assign tif.ready = !fifo_empty
		&& (scoreboard & dep_bitmap) == '0
		&& !wb_conflict
		&& thread_enable
		&& !blocked
		&& !tif.flush;

	always_comb
	begin
		wb_clear_bitmap = '0;
		if (wb_writeback_en && wb_writeback_thread_idx == TIDX_W'(THREAD_ID))
			wb_clear_bitmap = reg_bitmap(wb_writeback_is_vector, wb_writeback_reg);
	end

	// Completed and rolled back registers are released before the new destination is set
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			scoreboard <= '0;
			blocked <= 1'b0;
		end
		else
		begin
			scoreboard <= (scoreboard & ~(wb_clear_bitmap | tif.clear_bitmap))
				| (tif.grant ? dest_bitmap : '0);

			// A miss that is filled in the same cycle it is reported leaves the thread running
			blocked <= (blocked | suspend) & ~wake;
		end
	end

	// Fetch enable must have dropped early enough for the FIFO to absorb what is in flight
	assert property (@(posedge clk) disable iff (reset) enqueue |-> !fifo_full);

	// The data cache reports a miss only for a thread that was still running
	assert property (@(posedge clk) disable iff (reset) suspend |-> !blocked);

endmodule

// ==== verilog/ts_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Thread select stage definitions
// Decoded instruction layout, execution pipeline selector and the register
// scoreboard format shared by every block of the stage
////////////////////////////////////////////////////////////////////////////

package ts_pkg;

	// Selects one of 32 scalar or 32 vector registers
	typedef logic [4:0] reg_idx_t;

	// Execution pipeline that the instruction is sent to
	// The pipelines differ in length and merge again at writeback
	typedef enum logic [1:0]
	{
		PIPE_SCYCLE_ARITH,
		PIPE_MCYCLE_ARITH,
		PIPE_MEM
	} pipeline_sel_t;

	// Instruction as it leaves decode
	// The tag is not looked at here and travels with the instruction unchanged
	typedef struct packed
	{
		logic has_scalar1;
		reg_idx_t scalar_sel1;
		logic has_scalar2;
		reg_idx_t scalar_sel2;
		logic has_vector1;
		reg_idx_t vector_sel1;
		logic has_vector2;
		reg_idx_t vector_sel2;
		logic has_dest;
		logic dest_is_vector;
		reg_idx_t dest_reg;
		pipeline_sel_t pipeline_sel;
		logic [7:0] tag;
	} decoded_instruction_t;

	// One busy bit per register
	// Scalar registers sit in bits 0 to 31 and vector registers in bits 32 to 63
	typedef logic [63:0] scoreboard_t;

	// Issue stages remembered so a rollback can release their destinations
	localparam int ROLLBACK_STAGES = 4;

	// Cycles ahead that writeback port use is reserved
	localparam int WRITEBACK_ALLOC_STAGES = 4;

	// Fetch stops once fewer than this many FIFO entries are free
	localparam int ALMOST_FULL_MARGIN = 2;

	// Scoreboard bit of one register
	// The vector flag lands on bit 5 of the index, which is the upper half
	function automatic scoreboard_t reg_bitmap(input logic is_vector, input reg_idx_t idx);
		scoreboard_t bitmap;
		bitmap = '0;
		bitmap[{is_vector, idx}] = 1'b1;
		return bitmap;
	endfunction

endpackage
